// ==== Bender.yml ====
package:
  name: instr_fetch

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/pc_generator.sv
      - rtl/branch_predictor.sv
      - rtl/instr_queue.sv
      - rtl/instr_fetch.sv
  - target: test
    files:
      - verification/fetch_props.sv
      - verification/fetch_tb.sv

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
	input  logic                                                clk,
	input  logic                                                rst,
	input  fetch_pkg::vaddr_t                                   line_vaddr,
	input  fetch_pkg::instr_word_u     [fetch_pkg::fetch_num-1:0] instr,
	input  logic                       [fetch_pkg::fetch_num-1:0] instr_valid,
	input  fetch_pkg::branch_resolved_t                         resolved_branch,
	output fetch_pkg::branch_predict_t [fetch_pkg::fetch_num-1:0] predict,
	output logic                                                predict_valid,
	output fetch_pkg::vaddr_t                                   predict_vaddr
);

	// two-bit saturating counters, msb is the taken guess
	logic [1:0] bht [fetch_pkg::bht_size];

	logic [fetch_pkg::bht_index_width-1:0] update_index;
	logic [1:0]                            update_ctr;

	for (genvar i = 0; i < fetch_pkg::fetch_num; i++) begin : gen_slot
		fetch_pkg::vaddr_t                     slot_vaddr;
		fetch_pkg::vaddr_t                     jump_target;
		fetch_pkg::vaddr_t                     branch_target;
		logic [fetch_pkg::bht_index_width-1:0] bht_index;
		logic                                  is_jump;
		logic                                  is_branch;
		fetch_pkg::branch_predict_t            slot_predict;

		assign slot_vaddr = fetch_pkg::align_vaddr(line_vaddr) + 32'(i * 4);

		// j format view
		assign is_jump = (instr[i].j_fmt.opcode == fetch_pkg::op_j) ||
			(instr[i].j_fmt.opcode == fetch_pkg::op_jal);
		assign jump_target = {slot_vaddr[31:28], instr[i].j_fmt.target, 2'b00};

		// i format view, no delay slot so offset is from the next word
		assign is_branch = (instr[i].i_fmt.opcode == fetch_pkg::op_beq) ||
			(instr[i].i_fmt.opcode == fetch_pkg::op_bne);
		assign branch_target = slot_vaddr + 32'd4 +
			{{14{instr[i].i_fmt.imm[15]}}, instr[i].i_fmt.imm, 2'b00};

		assign bht_index = slot_vaddr[2 +: fetch_pkg::bht_index_width];

		always_comb begin
			if (is_jump) begin
				slot_predict.kind   = fetch_pkg::cf_jump;
				slot_predict.taken  = instr_valid[i];
				slot_predict.target = jump_target;
			end else if (is_branch) begin
				slot_predict.kind   = fetch_pkg::cf_branch;
				slot_predict.taken  = instr_valid[i] & bht[bht_index][1];
				slot_predict.target = branch_target;
			end else begin
				slot_predict.kind   = fetch_pkg::cf_none;
				slot_predict.taken  = 1'b0;
				slot_predict.target = slot_vaddr + 32'd4;
			end
		end

		assign predict[i] = slot_predict;
	end

	// the lowest taken slot steers the next fetch
	always_comb begin
		predict_valid = 1'b0;
		predict_vaddr = '0;
		for (int i = fetch_pkg::fetch_num - 1; i >= 0; i--) begin
			if (predict[i].taken) begin
				predict_valid = 1'b1;
				predict_vaddr = predict[i].target;
			end
		end
	end

	assign update_index = resolved_branch.pc[2 +: fetch_pkg::bht_index_width];
	assign update_ctr   = bht[update_index];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			// weakly not taken
			for (int i = 0; i < fetch_pkg::bht_size; i++) begin
				bht[i] <= 2'b01;
			end
		end else if (resolved_branch.valid) begin
			if (resolved_branch.taken && update_ctr != 2'b11) begin
				bht[update_index] <= update_ctr + 2'd1;
			end else if (!resolved_branch.taken && update_ctr != 2'b00) begin
				bht[update_index] <= update_ctr - 2'd1;
			end
		end
	end

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

	// fetch geometry
	localparam int fetch_num        = 2;
	localparam int fetch_width      = $clog2(fetch_num);
	localparam int addr_align_width = 3;
	localparam int line_bytes       = fetch_num * 4;

	// storage sizes
	localparam int queue_depth      = 8;
	localparam int queue_ptr_width  = $clog2(queue_depth);
	localparam int bht_size         = 64;
	localparam int bht_index_width  = $clog2(bht_size);

	typedef logic [31:0] vaddr_t;

	localparam vaddr_t reset_vec = 32'h0000_1000;

	// control-flow opcodes
	localparam logic [5:0] op_j   = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} instr_i_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} instr_j_t;

	// same word, read as branch or as jump
	typedef union packed {
		instr_i_t i_fmt;
		instr_j_t j_fmt;
	} instr_word_u;

	typedef enum logic [1:0] {
		cf_none   = 2'd0,
		cf_branch = 2'd1,
		cf_jump   = 2'd2
	} cf_kind_e;

	typedef struct packed {
		logic     taken;
		cf_kind_e kind;
		vaddr_t   target;
	} branch_predict_t;

	// resolve info coming back from execute
	typedef struct packed {
		logic   valid;
		vaddr_t pc;
		logic   taken;
		logic   mispredict;
		vaddr_t target;
	} branch_resolved_t;

	typedef struct packed {
		logic   read;
		vaddr_t vaddr;
		logic   flush;
	} icache_req_t;

	typedef struct packed {
		logic                     stall;
		logic [fetch_num*32-1:0]  data;
	} icache_res_t;

	typedef struct packed {
		vaddr_t          vaddr;
		instr_word_u     instr;
		branch_predict_t predict;
	} fetch_entry_t;

	function automatic vaddr_t align_vaddr(input vaddr_t addr);
		return {addr[31:addr_align_width], {addr_align_width{1'b0}}};
	endfunction

endpackage

// ==== rtl/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        flush_pc,
	input  fetch_pkg::vaddr_t           flush_vaddr,
	input  fetch_pkg::branch_resolved_t resolved_branch,
	input  fetch_pkg::icache_res_t      icache_res,
	input  logic                        fetch_ready,
	output fetch_pkg::icache_req_t      icache_req,
	output fetch_pkg::fetch_entry_t     fetch_entry,
	output logic                        fetch_valid
);

	logic              redirect;
	logic              hold_pc;
	logic              queue_full;
	fetch_pkg::vaddr_t pc;

	// stage 2 state
	logic                                s2_valid;
	logic                                s2_fresh;
	fetch_pkg::vaddr_t                   s2_vaddr;
	logic [fetch_pkg::fetch_num*32-1:0]  s2_line;
	logic [fetch_pkg::fetch_num*32-1:0]  s2_line_q;
	fetch_pkg::vaddr_t                   line_vaddr;
	logic [fetch_pkg::fetch_width-1:0]   fetch_offset;

	fetch_pkg::instr_word_u     [fetch_pkg::fetch_num-1:0] instr;
	logic                       [fetch_pkg::fetch_num-1:0] instr_valid;
	logic                       [fetch_pkg::fetch_num-1:0] push_mask;
	fetch_pkg::branch_predict_t [fetch_pkg::fetch_num-1:0] predict;
	fetch_pkg::fetch_entry_t    [fetch_pkg::fetch_num-1:0] push_entry;
	logic                                                  predict_valid;
	fetch_pkg::vaddr_t                                     predict_vaddr;
	logic                                                  taken_seen;

	assign redirect = flush_pc | (resolved_branch.valid & resolved_branch.mispredict);
	assign hold_pc  = (icache_res.stall | queue_full) & ~redirect;

	// stage 1, line request straight from the pc register
	assign icache_req.read  = 1'b1;
	assign icache_req.vaddr = fetch_pkg::align_vaddr(pc);
	assign icache_req.flush = redirect;

	pc_generator i_pc_generator (
		.clk,
		.rst,
		.hold_pc,
		.flush_pc,
		.flush_vaddr,
		.resolved_branch,
		.predict_valid,
		.predict_vaddr,
		.pc
	);

	// a taken prediction squashes the sequential line fetched alongside it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s2_valid <= 1'b0;
			s2_fresh <= 1'b0;
			s2_vaddr <= '0;
		end else begin
			s2_fresh <= ~hold_pc;
			if (redirect) begin
				s2_valid <= 1'b0;
			end else if (!hold_pc) begin
				s2_valid <= ~predict_valid;
				s2_vaddr <= pc;
			end
		end
	end

	// cache data belongs to stage 2 only right after it loaded
	// later cycles of a hold use the captured copy
	assign s2_line = s2_fresh ? icache_res.data : s2_line_q;

	always_ff @(posedge clk) begin
		s2_line_q <= s2_line;
	end

	assign line_vaddr   = fetch_pkg::align_vaddr(s2_vaddr);
	assign fetch_offset = s2_vaddr[2 +: fetch_pkg::fetch_width];

	for (genvar i = 0; i < fetch_pkg::fetch_num; i++) begin : gen_unpack
		assign instr[i]       = s2_line[i*32 +: 32];
		assign instr_valid[i] = s2_valid & (int'(fetch_offset) <= i);
		assign push_entry[i]  = '{
			vaddr:   line_vaddr + 32'(i * 4),
			instr:   instr[i],
			predict: predict[i]
		};
	end

	// drop slots behind a predicted taken one
	always_comb begin
		taken_seen = 1'b0;
		for (int i = 0; i < fetch_pkg::fetch_num; i++) begin
			push_mask[i] = instr_valid[i] & ~taken_seen & ~hold_pc;
			taken_seen   = taken_seen | (instr_valid[i] & predict[i].taken);
		end
	end

	branch_predictor i_branch_predictor (
		.clk,
		.rst,
		.line_vaddr,
		.instr,
		.instr_valid,
		.resolved_branch,
		.predict,
		.predict_valid,
		.predict_vaddr
	);

	instr_queue i_instr_queue (
		.clk,
		.rst,
		.flush       ( redirect   ),
		.push_entry,
		.push_mask,
		.fetch_ready,
		.full        ( queue_full ),
		.fetch_entry,
		.fetch_valid
	);

endmodule

// ==== rtl/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             flush,
	input  fetch_pkg::fetch_entry_t [fetch_pkg::fetch_num-1:0] push_entry,
	input  logic                    [fetch_pkg::fetch_num-1:0] push_mask,
	input  logic                                             fetch_ready,
	output logic                                             full,
	output fetch_pkg::fetch_entry_t                          fetch_entry,
	output logic                                             fetch_valid
);

	fetch_pkg::fetch_entry_t mem [fetch_pkg::queue_depth];

	logic [fetch_pkg::queue_ptr_width-1:0] head;
	logic [fetch_pkg::queue_ptr_width-1:0] tail;
	logic [fetch_pkg::queue_ptr_width:0]   count;
	logic [fetch_pkg::queue_ptr_width:0]   push_num;
	logic [fetch_pkg::queue_ptr_width-1:0] wr_ptr [fetch_pkg::fetch_num];
	logic                                  pop;

	// pack the kept slots into consecutive entries
	always_comb begin
		push_num = '0;
		for (int i = 0; i < fetch_pkg::fetch_num; i++) begin
			wr_ptr[i] = tail + push_num[fetch_pkg::queue_ptr_width-1:0];
			if (push_mask[i]) begin
				push_num = push_num + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < fetch_pkg::fetch_num; i++) begin
			if (push_mask[i] && !flush) begin
				mem[wr_ptr[i]] <= push_entry[i];
			end
		end
	end

	// nothing stale goes out while the queue is being cleared
	assign fetch_valid = (count != '0) & ~flush;
	assign fetch_entry = mem[head];
	assign pop         = fetch_valid & fetch_ready;

	// room for a whole line is needed before the next push
	assign full = (fetch_pkg::queue_depth - int'(count)) < fetch_pkg::fetch_num;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + {{(fetch_pkg::queue_ptr_width-1){1'b0}}, pop};
			tail  <= tail + push_num[fetch_pkg::queue_ptr_width-1:0];
			count <= count + push_num - {{fetch_pkg::queue_ptr_width{1'b0}}, pop};
		end
	end

endmodule

// ==== rtl/pc_generator.sv ====
`timescale 1ns/1ps

module pc_generator (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold_pc,
	input  logic                        flush_pc,
	input  fetch_pkg::vaddr_t           flush_vaddr,
	input  fetch_pkg::branch_resolved_t resolved_branch,
	input  logic                        predict_valid,
	input  fetch_pkg::vaddr_t           predict_vaddr,
	output fetch_pkg::vaddr_t           pc
);

	fetch_pkg::vaddr_t pc_next;
	fetch_pkg::vaddr_t next_line;
	logic              mispredict;

	assign mispredict = resolved_branch.valid & resolved_branch.mispredict;

	// sequential fetch always restarts on a line boundary
	assign next_line = fetch_pkg::align_vaddr(pc) + 32'(fetch_pkg::line_bytes);

	always_comb begin
		if (flush_pc) begin
			pc_next = flush_vaddr;
		end else if (mispredict) begin
			pc_next = resolved_branch.target;
		end else if (hold_pc) begin
			pc_next = pc;
		end else if (predict_valid) begin
			pc_next = predict_vaddr;
		end else begin
			pc_next = next_line;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= fetch_pkg::reset_vec;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== verification/fetch_props.sv ====
`timescale 1ns/1ps

module fetch_props (
	input logic                                             clk,
	input logic                                             rst,
	input logic                                             flush,
	input logic                    [fetch_pkg::fetch_num-1:0] push_mask,
	input logic                                             fetch_ready,
	input logic                                             fetch_valid,
	input fetch_pkg::fetch_entry_t                          fetch_entry,
	input logic                    [fetch_pkg::queue_ptr_width:0] count
);

	int fail_count = 0;

	// a waiting entry holds still unless a flush drops it
	held_entry: assert property (@(posedge clk) disable iff (rst)
		fetch_valid && !fetch_ready |=> flush || (fetch_valid && $stable(fetch_entry)))
	else begin
		fail_count++;
		$error("queue output changed while it waited for fetch_ready");
	end

	reset_quiet: assert property (@(posedge clk) rst |-> !fetch_valid)
	else begin
		fail_count++;
		$error("fetch_valid high during reset");
	end

	// pushes never run past the buffer
	no_overflow: assert property (@(posedge clk) disable iff (rst)
		!flush |-> int'(count) + $countones(push_mask) <= fetch_pkg::queue_depth)
	else begin
		fail_count++;
		$error("queue push would overflow the buffer");
	end

endmodule

bind instr_queue fetch_props i_fetch_props (.*);

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

	localparam int random_cycles  = 3000;
	localparam int planned_cycles = random_cycles + 200;

	logic                        clk;
	logic                        rst;
	logic                        flush_pc;
	fetch_pkg::vaddr_t           flush_vaddr;
	fetch_pkg::branch_resolved_t resolved_branch;
	fetch_pkg::icache_res_t      icache_res;
	logic                        fetch_ready;
	fetch_pkg::icache_req_t      icache_req;
	fetch_pkg::fetch_entry_t     fetch_entry;
	logic                        fetch_valid;

	// program image, mirrored counters and cache model state
	fetch_pkg::instr_word_u image [256];
	logic [1:0]             ctr_model [fetch_pkg::bht_size];
	fetch_pkg::vaddr_t      exp_vaddr;
	fetch_pkg::vaddr_t      line_addr;
	logic                   line_taken;
	logic [31:0]            rand_state;
	string                  test_name;
	int                     checked;
	int                     trained_hits;
	logic                   watch_trained;

	instr_fetch i_instr_fetch (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(planned_cycles * 4 * 20);
		fail_run("watchdog timeout, the fetch stream stopped making progress");
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	// J/I decode of one word, branch direction from the mirror
	function automatic fetch_pkg::branch_predict_t expect_predict(input fetch_pkg::vaddr_t pc,
		input fetch_pkg::instr_word_u w);
		fetch_pkg::branch_predict_t p;
		logic [5:0]                 op;

		op       = w.j_fmt.opcode;
		p.taken  = 1'b0;
		p.kind   = fetch_pkg::cf_none;
		p.target = pc + 32'd4;
		if (op == fetch_pkg::op_j || op == fetch_pkg::op_jal) begin
			p.taken  = 1'b1;
			p.kind   = fetch_pkg::cf_jump;
			p.target = {pc[31:28], w.j_fmt.target, 2'b00};
		end else if (op == fetch_pkg::op_beq || op == fetch_pkg::op_bne) begin
			p.taken  = ctr_model[pc[7:2]][1];
			p.kind   = fetch_pkg::cf_branch;
			p.target = pc + 32'd4 + 32'($signed(w.i_fmt.imm)) * 4;
		end
		return p;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_vaddr(input string what, input fetch_pkg::vaddr_t exp, act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s %s: expected %h actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_instr(input string what, input fetch_pkg::instr_word_u exp, act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s %s: expected %h actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_predict(input string what, input fetch_pkg::branch_predict_t exp, act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s %s: expected %h actual %h",
				test_name, what, exp, act));
	endtask

	task automatic check_flag(input string what, input logic exp, act);
		if (exp !== act)
			fail_run($sformatf("[ERROR] %s %s: expected %b actual %b",
				test_name, what, exp, act));
	endtask

	task automatic check_count(input string what, input int exp, act);
		if (exp != act)
			fail_run($sformatf("[ERROR] %s %s: expected %0d actual %0d",
				test_name, what, exp, act));
	endtask

	// sample at the rising edge, then drive the next cycle on the falling edge
	task automatic cycle_step(input logic stall, ready, flush, input fetch_pkg::vaddr_t target,
		input fetch_pkg::branch_resolved_t res);
		fetch_pkg::instr_word_u     exp_instr;
		fetch_pkg::branch_predict_t exp_pred;
		logic [5:0]                 idx;
		logic                       exp_flush;

		@(posedge clk);
		line_taken = !icache_res.stall;
		line_addr  = icache_req.vaddr;
		// cache sees a flush on every redirect
		exp_flush = flush_pc | (resolved_branch.valid & resolved_branch.mispredict);
		check_flag("cache read", 1'b1, icache_req.read);
		check_flag("cache flush", exp_flush, icache_req.flush);
		if (fetch_valid && fetch_ready) begin
			exp_instr = image[exp_vaddr[9:2]];
			exp_pred  = expect_predict(exp_vaddr, exp_instr);
			check_vaddr("vaddr", exp_vaddr, fetch_entry.vaddr);
			check_instr("instr", exp_instr, fetch_entry.instr);
			check_predict("predict", exp_pred, fetch_entry.predict);
			if (watch_trained && exp_pred.kind == fetch_pkg::cf_branch && exp_pred.taken)
				trained_hits++;
			watch_trained = 1'b0;
			exp_vaddr = exp_pred.taken ? exp_pred.target : exp_vaddr + 32'd4;
			checked++;
		end
		// saturating counter mirror
		if (resolved_branch.valid) begin
			idx = resolved_branch.pc[7:2];
			if (resolved_branch.taken)
				ctr_model[idx] = (ctr_model[idx] == 2'b11) ? 2'b11 : ctr_model[idx] + 2'd1;
			else
				ctr_model[idx] = (ctr_model[idx] == 2'b00) ? 2'b00 : ctr_model[idx] - 2'd1;
		end
		if (flush_pc)
			exp_vaddr = flush_vaddr;
		else if (resolved_branch.valid && resolved_branch.mispredict)
			exp_vaddr = resolved_branch.target;
		@(negedge clk);
		if (line_taken)
			icache_res.data = {image[line_addr[9:2] + 8'd1], image[line_addr[9:2]]};
		icache_res.stall = stall;
		fetch_ready      = ready;
		flush_pc         = flush;
		flush_vaddr      = target;
		resolved_branch  = res;
	endtask

	initial begin
		fetch_pkg::vaddr_t           bpc;
		fetch_pkg::branch_resolved_t res;
		logic [31:0]                 r;
		logic [31:0]                 a;
		int                          start;

		rst             = 1'b1;
		flush_pc        = 1'b0;
		flush_vaddr     = '0;
		resolved_branch = '0;
		icache_res      = '0;
		fetch_ready     = 1'b1;
		rand_state      = 32'd53632;
		exp_vaddr       = fetch_pkg::reset_vec;
		line_taken      = 1'b0;
		line_addr       = '0;
		checked         = 0;
		trained_hits    = 0;
		watch_trained   = 1'b0;
		bpc             = '0;
		// plain words, beq/bne with short offsets, jumps into the image
		for (int i = 0; i < 256; i++) begin
			r = next_rand();
			if (r[3:0] < 4'd2)
				image[i] = {fetch_pkg::op_j, 26'h400 + 26'(r[11:4])};
			else if (r[3:0] < 4'd5)
				image[i] = {r[4] ? fetch_pkg::op_bne : fetch_pkg::op_beq, r[25:16],
					{11{r[15]}}, r[15:11]};
			else
				image[i] = {6'h08, r[25:0]};
		end
		for (int i = 255; i >= 0; i--) begin
			if (image[i].i_fmt.opcode inside {fetch_pkg::op_beq, fetch_pkg::op_bne})
				bpc = {22'h4, 8'(i), 2'b00};
		end
		for (int i = 0; i < fetch_pkg::bht_size; i++)
			ctr_model[i] = 2'b01;

		test_name = "reset";
		repeat (4) begin
			@(posedge clk);
			if (fetch_valid)
				fail_run("fetch_valid was high during reset");
		end
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 40 && checked < 4; i++)
			cycle_step(1'b0, 1'b1, 1'b0, '0, '0);
		check_count("entries after reset", 4, checked);

		test_name = "odd flush";
		// a mispredict in the same cycle loses to the flush
		res            = '0;
		res.valid      = 1'b1;
		res.mispredict = 1'b1;
		res.pc         = fetch_pkg::reset_vec;
		res.target     = 32'h0000_1100;
		cycle_step(1'b0, 1'b1, 1'b1, 32'h0000_1024, res);
		start = checked;
		for (int i = 0; i < 40 && checked < start + 2; i++)
			cycle_step(1'b0, 1'b1, 1'b0, '0, '0);
		check_count("entries after flush", start + 2, checked);

		test_name = "random";
		for (int i = 0; i < random_cycles; i++) begin
			r = next_rand();
			a = next_rand();
			res            = '0;
			res.valid      = r[16:11] == 6'd0;
			res.taken      = r[17];
			res.mispredict = 1'b1;
			res.pc         = {22'h4, a[17:10], 2'b00};
			res.target     = {22'h4, a[9:2], 2'b00};
			cycle_step(r[1:0] == 2'b00, r[4:3] != 2'b00, r[10:5] == 6'd0,
				{22'h4, r[31:24], 2'b00}, res);
		end

		test_name = "training";
		for (int i = 0; i < 64 && !i_instr_fetch.queue_full; i++)
			cycle_step(1'b0, 1'b0, 1'b0, '0, '0);
		if (!i_instr_fetch.queue_full)
			fail_run("queue did not fill while fetch_ready was low");
		res        = '0;
		res.valid  = 1'b1;
		res.taken  = 1'b1;
		res.pc     = bpc;
		res.target = bpc + 32'd4;
		cycle_step(1'b0, 1'b0, 1'b0, '0, res);
		cycle_step(1'b0, 1'b0, 1'b0, '0, res);
		cycle_step(1'b0, 1'b1, 1'b1, bpc, '0);
		watch_trained = 1'b1;
		for (int i = 0; i < 40 && watch_trained; i++)
			cycle_step(1'b0, 1'b1, 1'b0, '0, '0);
		check_count("taken branch after training", 1, trained_hits);

		if (i_instr_fetch.i_instr_queue.i_fetch_props.fail_count != 0) begin
			fail_run("a bound assertion on the instruction queue failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
rtl/fetch_pkg.sv
rtl/pc_generator.sv
rtl/branch_predictor.sv
rtl/instr_queue.sv
rtl/instr_fetch.sv
verification/fetch_props.sv
verification/fetch_tb.sv
